// ==== gradient_pkg.sv ====
`default_nettype none

// Widths and stage payload types shared by the gradient pipeline.
package gradient_pkg;

    localparam int PIX_W   = 8;
    localparam int GRAD_W  = 10;
    localparam int ADDR_W  = 16;
    localparam int COORD_W = 8;

    typedef logic [PIX_W-1:0] pixel_t;

    // One element leaving the fetch stage.
    // Pad elements only push the last image row through the line buffer.
    typedef struct packed {
        logic               pad;
        logic [COORD_W-1:0] x;
        logic [COORD_W-1:0] y;
        pixel_t             pix;
    } pix_beat_t;

    // A pixel together with the two neighbours needed for the differences.
    typedef struct packed {
        logic [COORD_W-1:0] x;
        logic [COORD_W-1:0] y;
        pixel_t             center;
        pixel_t             right;
        pixel_t             below;
    } window_t;

    // Result word as stored in the gradient memory, with Gx in the upper half.
    typedef struct packed {
        logic signed [GRAD_W-1:0] gx;
        logic signed [GRAD_W-1:0] gy;
    } grad_t;

    typedef struct packed {
        logic [COORD_W-1:0] x;
        logic [COORD_W-1:0] y;
        grad_t              grad;
    } grad_beat_t;

endpackage

`default_nettype wire

// ==== pixel_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_fetch #(
    parameter int IMG_W = 32,
    parameter int IMG_H = 16
) (
    input  logic                             clk,
    input  logic                             reset,
    output logic                             img_rd,
    output logic [gradient_pkg::ADDR_W-1:0]  img_addr,
    input  gradient_pkg::pixel_t             img_di,
    output logic                             beat_valid,
    output gradient_pkg::pix_beat_t          beat
);
    import gradient_pkg::*;

    localparam logic [COORD_W-1:0] X_LAST = COORD_W'(IMG_W - 1);
    localparam logic [COORD_W-1:0] Y_LAST = COORD_W'(IMG_H - 1);

    typedef enum logic [1:0] {
        PH_READ,
        PH_PAD,
        PH_IDLE
    } phase_t;

    phase_t             phase;
    logic [COORD_W-1:0] cnt_x;
    logic [COORD_W-1:0] cnt_y;
    logic [ADDR_W-1:0]  rd_addr;

    // Slot presented to the image memory in the current cycle.
    logic               iss_valid;
    logic               iss_pad;
    logic [COORD_W-1:0] iss_x;
    logic [COORD_W-1:0] iss_y;

    // Same slot one cycle later, when img_di carries its pixel.
    logic               dat_valid;
    logic               dat_pad;
    logic [COORD_W-1:0] dat_x;
    logic [COORD_W-1:0] dat_y;

    assign img_rd = iss_valid & ~iss_pad;

    // Raster counter, followed by one row of pad slots and then a permanent stop.
    always_ff @(posedge clk) begin
        if (reset) begin
            phase     <= PH_READ;
            cnt_x     <= '0;
            cnt_y     <= '0;
            rd_addr   <= '0;
            iss_valid <= 1'b0;
            iss_pad   <= 1'b0;
        end else begin
            iss_valid <= (phase != PH_IDLE);
            iss_pad   <= (phase == PH_PAD);
            case (phase)
                PH_READ: begin
                    rd_addr <= rd_addr + 1'b1;
                    if (cnt_x == X_LAST) begin
                        cnt_x <= '0;
                        if (cnt_y == Y_LAST) begin
                            phase <= PH_PAD;
                        end else begin
                            cnt_y <= cnt_y + 1'b1;
                        end
                    end else begin
                        cnt_x <= cnt_x + 1'b1;
                    end
                end
                PH_PAD: begin
                    cnt_x <= cnt_x + 1'b1;
                    if (cnt_x == X_LAST) begin
                        phase <= PH_IDLE;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dat_valid  <= 1'b0;
            beat_valid <= 1'b0;
        end else begin
            dat_valid  <= iss_valid;
            beat_valid <= dat_valid;
        end
    end

    always_ff @(posedge clk) begin
        img_addr  <= rd_addr;
        iss_x     <= cnt_x;
        iss_y     <= cnt_y;
        dat_pad   <= iss_pad;
        dat_x     <= iss_x;
        dat_y     <= iss_y;
        beat.pad  <= dat_pad;
        beat.x    <= dat_x;
        beat.y    <= dat_y;
        // No read was issued for a pad slot, so img_di is not looked at.
        beat.pix  <= dat_pad ? '0 : img_di;
    end

endmodule

`default_nettype wire

// ==== line_window.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_window #(
    parameter int IMG_W = 32
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      beat_valid,
    input  gradient_pkg::pix_beat_t   beat,
    output logic                      win_valid,
    output gradient_pkg::window_t     win
);
    import gradient_pkg::*;

    // Entry k holds the beat that arrived k+1 beats before the current one.
    // Together with the entering beat this spans IMG_W+1 raster positions.
    pix_beat_t        line_q [IMG_W];
    logic [IMG_W-1:0] fill_q;

    pix_beat_t center;
    pix_beat_t right;

    // The entering beat sits exactly one row below the oldest entry.
    assign center = line_q[IMG_W-1];
    assign right  = line_q[IMG_W-2];

    // Tracks which entries already hold a beat since reset.
    always_ff @(posedge clk) begin
        if (reset) begin
            fill_q <= '0;
        end else if (beat_valid) begin
            fill_q <= {fill_q[IMG_W-2:0], 1'b1};
        end
    end

    always_ff @(posedge clk) begin
        if (beat_valid) begin
            line_q[0] <= beat;
            for (int i = 1; i < IMG_W; i++) begin
                line_q[i] <= line_q[i-1];
            end
        end
    end

    // A window is produced only while the center is a real pixel.
    always_ff @(posedge clk) begin
        if (reset) begin
            win_valid <= 1'b0;
        end else begin
            win_valid <= beat_valid & fill_q[IMG_W-1] & ~center.pad;
        end
    end

    // In the last column the right entry is the next row's first pixel.
    // The calculate stage discards it there.
    always_ff @(posedge clk) begin
        win.x      <= center.x;
        win.y      <= center.y;
        win.center <= center.pix;
        win.right  <= right.pix;
        win.below  <= beat.pix;
    end

endmodule

`default_nettype wire

// ==== gradient_calc.sv ====
`timescale 1ns/1ps
`default_nettype none

module gradient_calc #(
    parameter int IMG_W = 32,
    parameter int IMG_H = 16
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        win_valid,
    input  gradient_pkg::window_t       win,
    output logic                        grad_valid,
    output gradient_pkg::grad_beat_t    gbeat
);
    import gradient_pkg::*;

    localparam logic [COORD_W-1:0] X_LAST = COORD_W'(IMG_W - 1);
    localparam logic [COORD_W-1:0] Y_LAST = COORD_W'(IMG_H - 1);

    logic signed [GRAD_W-1:0] gx_raw;
    logic signed [GRAD_W-1:0] gy_raw;

    // Pixels are unsigned, so both operands widen with zeros.
    // The difference spans -255 to 255 and fits GRAD_W bits.
    assign gx_raw = $signed(GRAD_W'(win.right)) - $signed(GRAD_W'(win.center));
    assign gy_raw = $signed(GRAD_W'(win.below)) - $signed(GRAD_W'(win.center));

    always_ff @(posedge clk) begin
        if (reset) begin
            grad_valid <= 1'b0;
        end else begin
            grad_valid <= win_valid;
        end
    end

    // There is no right neighbour in the last column and none below in the last row.
    always_ff @(posedge clk) begin
        gbeat.x       <= win.x;
        gbeat.y       <= win.y;
        gbeat.grad.gx <= (win.x == X_LAST) ? '0 : gx_raw;
        gbeat.grad.gy <= (win.y == Y_LAST) ? '0 : gy_raw;
    end

endmodule

`default_nettype wire

// ==== grad_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module grad_writer #(
    parameter int IMG_W = 32,
    parameter int IMG_H = 16
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             grad_valid,
    input  gradient_pkg::grad_beat_t         gbeat,
    output logic                             grad_wr,
    output logic [gradient_pkg::ADDR_W-1:0]  grad_addr,
    output gradient_pkg::grad_t              grad_do,
    output logic                             done
);
    import gradient_pkg::*;

    localparam logic [ADDR_W-1:0] ROW_LEN = ADDR_W'(IMG_W);
    // A full 256 by 256 frame needs one bit more than an address.
    localparam logic [ADDR_W:0]   LAST_WR = (ADDR_W + 1)'(IMG_W * IMG_H - 1);

    logic [ADDR_W-1:0] pix_addr;
    logic [ADDR_W:0]   wr_cnt;

    assign pix_addr = ADDR_W'(gbeat.y) * ROW_LEN + ADDR_W'(gbeat.x);

    always_ff @(posedge clk) begin
        grad_addr <= pix_addr;
        grad_do   <= gbeat.grad;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            grad_wr <= 1'b0;
            wr_cnt  <= '0;
            done    <= 1'b0;
        end else begin
            grad_wr <= grad_valid;
            if (grad_wr) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
            // Done rises in the cycle after the final write and holds until reset.
            if (grad_wr && wr_cnt == LAST_WR) begin
                done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== image_gradient_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module image_gradient_top #(
    parameter int IMG_W = 32,
    parameter int IMG_H = 16
) (
    input  logic                             clk,
    input  logic                             reset,
    output logic                             img_rd,
    output logic [gradient_pkg::ADDR_W-1:0]  img_addr,
    input  gradient_pkg::pixel_t             img_di,
    output logic                             grad_wr,
    output logic [gradient_pkg::ADDR_W-1:0]  grad_addr,
    output gradient_pkg::grad_t              grad_do,
    output logic                             done
);
    import gradient_pkg::*;

    logic       beat_valid;
    pix_beat_t  beat;
    logic       win_valid;
    window_t    win;
    logic       grad_valid;
    grad_beat_t gbeat;

    // Fetch, line window, calculate and write, one element per cycle throughout.
    pixel_fetch #(
        .IMG_W(IMG_W),
        .IMG_H(IMG_H)
    ) u_fetch (
        .clk        (clk),
        .reset      (reset),
        .img_rd     (img_rd),
        .img_addr   (img_addr),
        .img_di     (img_di),
        .beat_valid (beat_valid),
        .beat       (beat)
    );

    line_window #(
        .IMG_W(IMG_W)
    ) u_window (
        .clk        (clk),
        .reset      (reset),
        .beat_valid (beat_valid),
        .beat       (beat),
        .win_valid  (win_valid),
        .win        (win)
    );

    gradient_calc #(
        .IMG_W(IMG_W),
        .IMG_H(IMG_H)
    ) u_calc (
        .clk        (clk),
        .reset      (reset),
        .win_valid  (win_valid),
        .win        (win),
        .grad_valid (grad_valid),
        .gbeat      (gbeat)
    );

    grad_writer #(
        .IMG_W(IMG_W),
        .IMG_H(IMG_H)
    ) u_writer (
        .clk        (clk),
        .reset      (reset),
        .grad_valid (grad_valid),
        .gbeat      (gbeat),
        .grad_wr    (grad_wr),
        .grad_addr  (grad_addr),
        .grad_do    (grad_do),
        .done       (done)
    );

endmodule

`default_nettype wire

// ==== tb_image_gradient.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_image_gradient;
    import gradient_pkg::*;

    localparam int IMG_W = 32;
    localparam int IMG_H = 16;
    localparam int NPIX = IMG_W * IMG_H;
    localparam int CLK_HALF = 4;
    localparam int FRAME_CYCLES = NPIX + IMG_W + 50;
    localparam int NUM_RUNS = 3;
    localparam int WATCHDOG_CYCLES = 3 * FRAME_CYCLES * NUM_RUNS;

    logic              clk;
    logic              reset;
    logic              img_rd;
    logic [ADDR_W-1:0] img_addr;
    pixel_t            img_di;
    logic              grad_wr;
    logic [ADDR_W-1:0] grad_addr;
    grad_t             grad_do;
    logic              done;

    logic [7:0]        image [NPIX];
    logic [19:0]       captured [NPIX];
    int                write_count [NPIX];
    int                write_order [$];
    int                late_writes;
    int                out_of_range;
    int                rd_count;
    logic              rd_pending;
    logic [ADDR_W-1:0] rd_addr_q;
    int                seed;

    image_gradient_top #(
        .IMG_W(IMG_W),
        .IMG_H(IMG_H)
    ) u_dut (
        .clk       (clk),
        .reset     (reset),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .img_di    (img_di),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // The image memory registers a read request on the rising edge.
    always @(posedge clk) begin
        rd_pending <= img_rd;
        rd_addr_q  <= img_addr;
    end

    // Read data follows on the falling edge and stays for the rest of the cycle.
    always @(negedge clk) begin
        if (rd_pending) begin
            img_di <= image[rd_addr_q];
        end
    end

    // Reads walk the image once in raster order and stop after the last pixel.
    always @(negedge clk) begin
        if (!reset && img_rd) begin
            check_true(rd_count < NPIX, "a read was issued after the last image pixel");
            check_value("img_addr", 32'(img_addr), rd_count);
            rd_count++;
        end
    end

    // Gradient memory model. Outputs are sampled mid-cycle, where they are stable.
    always @(negedge clk) begin
        if (!reset && grad_wr) begin
            if (done) begin
                late_writes++;
            end
            if (grad_addr >= NPIX) begin
                out_of_range++;
            end else begin
                captured[grad_addr] = grad_do;
                write_count[grad_addr]++;
            end
            write_order.push_back(int'(grad_addr));
        end
    end

    // Gx is the right neighbour minus the pixel, Gy the pixel below minus the pixel.
    function automatic logic [19:0] expected_grad(input int x, input int y);
        int c;
        int gx;
        int gy;
        c  = int'(image[y * IMG_W + x]);
        gx = (x == IMG_W - 1) ? 0 : int'(image[y * IMG_W + x + 1]) - c;
        gy = (y == IMG_H - 1) ? 0 : int'(image[(y + 1) * IMG_W + x]) - c;
        return {gx[GRAD_W-1:0], gy[GRAD_W-1:0]};
    endfunction

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            $display("FAILED t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("Error at t=%0t: %s", $time, what);
            abort_run();
        end
    endtask

    // Kind 0 is random data, kind 1 alternates 0 and 255 along diagonals.
    task automatic fill_image(input int kind);
        for (int a = 0; a < NPIX; a++) begin
            if (kind == 0) begin
                image[a] = 8'($random(seed));
            end else begin
                image[a] = (((a % IMG_W) + (a / IMG_W)) % 2 == 1) ? 8'd255 : 8'd0;
            end
        end
    endtask

    task automatic run_frame(input int kind, input string label);
        int          cycles;
        int          a;
        logic [19:0] exp_word;
        @(negedge clk);
        reset = 1'b1;
        fill_image(kind);
        for (int i = 0; i < NPIX; i++) begin
            write_count[i] = 0;
            captured[i]    = '0;
        end
        write_order.delete();
        late_writes  = 0;
        out_of_range = 0;
        rd_count     = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_value("img_rd", 32'(img_rd), 0);
        check_value("grad_wr", 32'(grad_wr), 0);
        check_value("done", 32'(done), 0);
        reset = 1'b0;

        cycles = 0;
        while (!done && cycles < 2 * FRAME_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        check_true(done, "done did not rise within the expected frame time");

        // Done must hold, and nothing more may be written.
        repeat (IMG_W + 10) begin
            @(negedge clk);
            check_value("done", 32'(done), 1);
        end
        check_value("number of reads", rd_count, NPIX);
        check_value("writes after done", late_writes, 0);
        check_value("writes out of range", out_of_range, 0);
        check_value("number of writes", write_order.size(), NPIX);
        for (int i = 0; i < NPIX; i++) begin
            check_value($sformatf("grad_addr of write %0d", i), write_order[i], i);
            check_value($sformatf("write count of address %0d", i), write_count[i], 1);
        end

        for (int y = 0; y < IMG_H; y++) begin
            for (int x = 0; x < IMG_W; x++) begin
                a = y * IMG_W + x;
                exp_word = expected_grad(x, y);
                check_value($sformatf("grad_do[%0d]", a), 32'(captured[a]), 32'(exp_word));
                if (x == IMG_W - 1) begin
                    check_value($sformatf("gx[%0d]", a), 32'(captured[a][19:10]), 0);
                end
                if (y == IMG_H - 1) begin
                    check_value($sformatf("gy[%0d]", a), 32'(captured[a][9:0]), 0);
                end
            end
        end
        check_value("grad_do bottom right", 32'(captured[NPIX-1]), 0);
        $display("Frame with %s image checked at t=%0t", label, $time);
    endtask

    initial begin
        seed   = 32'h941332e5;
        reset  = 1'b1;
        img_di = '0;
        run_frame(0, "random");
        run_frame(1, "striped");
        run_frame(0, "second random");
        $display("TEST RESULT: PASS");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the frames did not complete.",
                 WATCHDOG_CYCLES);
        abort_run();
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
gradient_pkg.sv
pixel_fetch.sv
line_window.sv
gradient_calc.sv
grad_writer.sv
image_gradient_top.sv
tb_image_gradient.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_image_gradient
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing
PASS_TEXT  := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
